// File: design/pci_ctrl_defs.svh
/*
 * Bus width and reset polarity macros shared by the PCI signal-timing core
 */
`ifndef PCI_CTRL_DEFS_SVH
`define PCI_CTRL_DEFS_SVH

// Width of the multiplexed address/data bus
`define PCI_AD_WIDTH 32

// Level of async_reset that clears the control state and output enables
`define PCI_RESET_LEVEL 1'b1

`endif

// File: design/pci_ctrl_pkg.sv
/*
 * Next-state code types for the PCI master signals FRAME and IRDY
 * and for the target signals DEVSEL, TRDY and STOP
 */
`default_nettype none

package pci_ctrl_pkg;

  // ==============================
  // Master side codes
  // ==============================

  // FRAME code, decoded against the late TRDY and STOP samples
  typedef enum logic [1:0] {
    frame_off         = 2'b00,
    frame_hold        = 2'b01,
    frame_end_on_stop = 2'b10,
    frame_end_on_any  = 2'b11
  } pci_frame_code_e;

  // IRDY code, codes above irdy_on decode the same as irdy_on
  typedef enum logic [2:0] {
    irdy_off       = 3'b000,
    irdy_on_abort  = 3'b001,
    irdy_hold_last = 3'b010,
    irdy_hold_idle = 3'b011,
    irdy_on        = 3'b100
  } pci_irdy_code_e;

  // ==============================
  // Target side codes
  // ==============================

  // One code per target signal, 001 decodes as tgt_off and 101 to 111 as tgt_on
  typedef enum logic [2:0] {
    tgt_off       = 3'b000,
    tgt_hold_last = 3'b010,
    tgt_hold_idle = 3'b011,
    tgt_on        = 3'b100
  } pci_target_code_e;

endpackage

`default_nettype wire

// File: design/pci_ctrl_ifs.sv
/*
 * Signal bundles between the PCI sampler, the next-state decoders
 * and the pad drivers: sampled inputs, next values, registered outputs
 */
`include "pci_ctrl_defs.svh"
`default_nettype none

// Bypassed control samples, valid combinationally within the cycle
interface pci_sample_if;
  logic frame_in;
  logic irdy_in;
  logic trdy_in;
  logic stop_in;

  modport src (output frame_in, irdy_in, trdy_in, stop_in);
  modport dst (input frame_in, irdy_in, trdy_in, stop_in);
endinterface

// Next values for the output registers
interface pci_next_if;
  logic frame_next;
  logic irdy_next;
  logic devsel_next;
  logic trdy_next;
  logic stop_next;

  // The master decoder owns FRAME and IRDY, the target decoder the rest
  modport master (output frame_next, irdy_next);
  modport target (output devsel_next, trdy_next, stop_next);
  modport dst (input frame_next, irdy_next, devsel_next, trdy_next, stop_next);
endinterface

// Registered pad values and enables, fed back for the post-flop bypass
interface pci_drive_if;
  logic                     frame_q;
  logic                     irdy_q;
  logic                     devsel_q;
  logic                     trdy_q;
  logic                     stop_q;
  logic [`PCI_AD_WIDTH-1:0] ad_q;
  logic                     master_oe;
  logic                     target_oe;
  logic                     ad_oe;

  modport src (output frame_q, irdy_q, devsel_q, trdy_q, stop_q, ad_q,
               master_oe, target_oe, ad_oe);
  modport dst (input frame_q, irdy_q, devsel_q, trdy_q, stop_q, ad_q,
               master_oe, target_oe, ad_oe);
endinterface

`default_nettype wire

// File: design/pci_bus_sampler.sv
/*
 * PCI input sampling with post-flop bypass and the registered AD sample
 */
`include "pci_ctrl_defs.svh"
`default_nettype none

module pci_bus_sampler (
  input  logic                     pci_clk,
  input  logic                     async_reset,
  input  logic                     frame_ext,
  input  logic                     irdy_ext,
  input  logic                     trdy_ext,
  input  logic                     stop_ext,
  input  logic [`PCI_AD_WIDTH-1:0] ad_ext,
  pci_drive_if.dst                 drive,
  pci_sample_if.src                sample,
  output logic [`PCI_AD_WIDTH-1:0] ad_in_prev
);

  // Bypassed AD value seen in the current cycle
  logic [`PCI_AD_WIDTH-1:0] ad_in_comb;

  // ==============================
  // Bypass selection
  // ==============================

  // When this chip drives a group, the pin only echoes our own register,
  // so the sample is taken from the register side of the pad instead
  assign sample.frame_in = drive.master_oe ? drive.frame_q : frame_ext;
  assign sample.irdy_in  = drive.master_oe ? drive.irdy_q  : irdy_ext;

  // TRDY and STOP belong to the target group
  assign sample.trdy_in  = drive.target_oe ? drive.trdy_q : trdy_ext;
  assign sample.stop_in  = drive.target_oe ? drive.stop_q : stop_ext;

  assign ad_in_comb = drive.ad_oe ? drive.ad_q : ad_ext;

  // ==============================
  // Registered AD sample
  // ==============================

  // The external data valid window is short, keep this flop near the pads
  always_ff @(posedge pci_clk)
  begin
    ad_in_prev <= ad_in_comb;
  end

  // While driving AD, the delayed sample must be the word that was on our own
  // output register one edge earlier
  a_ad_prev_bypass : assert property (
    @(posedge pci_clk) disable iff (async_reset == `PCI_RESET_LEVEL)
    drive.ad_oe |=> (ad_in_prev == $past(drive.ad_q))
  );

endmodule

`default_nettype wire

// File: design/pci_master_next_ctrl.sv
/*
 * Next FRAME and IRDY decode from the master codes and late TRDY/STOP
 */
`default_nettype none

module pci_master_next_ctrl (
  input  pci_ctrl_pkg::pci_frame_code_e frame_code,
  input  logic                          frame_force,
  input  pci_ctrl_pkg::pci_irdy_code_e  irdy_code,
  pci_sample_if.dst                     sample,
  pci_next_if.master                    nxt
);

  import pci_ctrl_pkg::*;

  // Four-case tables, indexed by {trdy, stop}
  // Bit 0 idle, bit 1 abort, bit 2 data, bit 3 data-last
  logic [3:0] frame_table;
  logic [3:0] irdy_table;
  logic [1:0] bus_case;

  // ==============================
  // Code tables
  // ==============================

  // The tables depend only on the early codes and settle well before
  // TRDY and STOP arrive
  always_comb
  begin
    frame_table = 4'b0000;
    case (frame_code)
      frame_off:         frame_table = 4'b0000;
      frame_hold:        frame_table = 4'b1101;
      frame_end_on_stop: frame_table = 4'b0101;
      frame_end_on_any:  frame_table = 4'b0001;
      default:           frame_table = 4'b0000;
    endcase
  end

  always_comb
  begin
    irdy_table = 4'b1111;
    case (irdy_code)
      irdy_off:       irdy_table = 4'b0000;
      irdy_on_abort:  irdy_table = 4'b0010;
      irdy_hold_last: irdy_table = 4'b1001;
      irdy_hold_idle: irdy_table = 4'b0001;
      // irdy_on and the unnamed codes above it keep IRDY asserted
      default:        irdy_table = 4'b1111;
    endcase
  end

  // ==============================
  // Late selection
  // ==============================

  // TRDY and STOP are the very late inputs, they only steer a 4:1 mux
  assign bus_case = {sample.trdy_in, sample.stop_in};

  // Force is also late and overrides the table
  assign nxt.frame_next = frame_force | frame_table[bus_case];
  assign nxt.irdy_next  = irdy_table[bus_case];

endmodule

`default_nettype wire

// File: design/pci_target_next_ctrl.sv
/*
 * Next DEVSEL, TRDY and STOP decode from the target codes and late FRAME/IRDY
 */
`default_nettype none

module pci_target_next_ctrl (
  input  pci_ctrl_pkg::pci_target_code_e devsel_code,
  input  pci_ctrl_pkg::pci_target_code_e trdy_code,
  input  pci_ctrl_pkg::pci_target_code_e stop_code,
  pci_sample_if.dst                      sample,
  pci_next_if.target                     nxt
);

  import pci_ctrl_pkg::*;

  // Case select {irdy, frame}: 0x idle, 10 data-last, 11 data
  logic [1:0] bus_case;

  // Shared target table, the same for all three signals
  function automatic logic tgt_decode(pci_target_code_e code, logic [1:0] sel);
    logic [3:0] table_bits;
    case (code)
      tgt_off:       table_bits = 4'b0000;
      tgt_hold_last: table_bits = 4'b1011;
      tgt_hold_idle: table_bits = 4'b0011;
      tgt_on:        table_bits = 4'b1111;
      // 001 behaves as off, 101 to 111 as on
      default:       table_bits = code[2] ? 4'b1111 : 4'b0000;
    endcase
    return table_bits[sel];
  endfunction

  // FRAME and IRDY arrive late and only pick a bit of each table
  assign bus_case = {sample.irdy_in, sample.frame_in};

  assign nxt.devsel_next = tgt_decode(devsel_code, bus_case);
  assign nxt.trdy_next   = tgt_decode(trdy_code, bus_case);
  assign nxt.stop_next   = tgt_decode(stop_code, bus_case);

  // A known STOP code with known bus samples from the sampler must
  // give a known STOP for the pad register
  always_comb
  begin
    if (!$isunknown({stop_code, sample.frame_in, sample.irdy_in}))
    begin
      a_stop_next_known : assert (!$isunknown(nxt.stop_next));
    end
  end

endmodule

`default_nettype wire

// File: design/pci_pad_drivers.sv
/*
 * PCI output registers, output-enable registers and the data latch enable
 */
`include "pci_ctrl_defs.svh"
`default_nettype none

module pci_pad_drivers (
  input  logic                     pci_clk,
  input  logic                     async_reset,
  input  logic                     master_oe_next,
  input  logic                     target_oe_next,
  input  logic                     ad_oe_next,
  input  logic                     master_expects_trdy,
  input  logic                     target_expects_irdy,
  input  logic                     new_data_unconditional,
  input  logic [`PCI_AD_WIDTH-1:0] ad_out_next,
  pci_sample_if.dst                sample,
  pci_next_if.dst                  nxt,
  pci_drive_if.src                 drive,
  output logic                     frame_out,
  output logic                     irdy_out,
  output logic                     devsel_out,
  output logic                     trdy_out,
  output logic                     stop_out,
  output logic [`PCI_AD_WIDTH-1:0] ad_out,
  output logic                     master_oe,
  output logic                     target_oe,
  output logic                     ad_oe
);

  // New AD word may be loaded this edge
  logic ad_out_en;

  // ==============================
  // Data latch enable
  // ==============================

  // Data advances when the other side accepts the current word, or at
  // the start of an address phase
  assign ad_out_en = (master_expects_trdy & sample.trdy_in)
                   | (target_expects_irdy & sample.irdy_in)
                   | new_data_unconditional;

  // ==============================
  // Output and enable registers
  // ==============================

  // The bus clock may be stopped, so the enables must drop on reset
  // itself and not wait for an edge
  always_ff @(posedge pci_clk or posedge async_reset)
  begin
    if (async_reset == `PCI_RESET_LEVEL)
    begin
      master_oe <= 1'b0;
      target_oe <= 1'b0;
      ad_oe     <= 1'b0;
    end
    else
    begin
      master_oe <= master_oe_next;
      target_oe <= target_oe_next;
      ad_oe     <= ad_oe_next;
    end
  end

  // Control outputs follow their decoded next values one edge later
  always_ff @(posedge pci_clk or posedge async_reset)
  begin
    if (async_reset == `PCI_RESET_LEVEL)
    begin
      frame_out  <= 1'b0;
      irdy_out   <= 1'b0;
      devsel_out <= 1'b0;
      trdy_out   <= 1'b0;
      stop_out   <= 1'b0;
      ad_out     <= '0;
    end
    else
    begin
      frame_out  <= nxt.frame_next;
      irdy_out   <= nxt.irdy_next;
      devsel_out <= nxt.devsel_next;
      trdy_out   <= nxt.trdy_next;
      stop_out   <= nxt.stop_next;
      // AD holds its word until the latch enable fires
      if (ad_out_en)
      begin
        ad_out <= ad_out_next;
      end
    end
  end

  // Register side of the pads, fed back to the sampler
  assign drive.frame_q   = frame_out;
  assign drive.irdy_q    = irdy_out;
  assign drive.devsel_q  = devsel_out;
  assign drive.trdy_q    = trdy_out;
  assign drive.stop_q    = stop_out;
  assign drive.ad_q      = ad_out;
  assign drive.master_oe = master_oe;
  assign drive.target_oe = target_oe;
  assign drive.ad_oe     = ad_oe;

  // No pad may be driven while the bus is held in reset
  a_oe_off_in_reset : assert property (
    @(posedge pci_clk) async_reset |-> !(master_oe | target_oe | ad_oe)
  );

endmodule

`default_nettype wire

// File: design/pci_signal_ctrl_top.sv
/*
 * PCI signal-timing core top level, joining sampler, decoders and pad drivers
 */
`include "pci_ctrl_defs.svh"
`default_nettype none

module pci_signal_ctrl_top (
  input  logic                           pci_clk,
  input  logic                           async_reset,
  // Pin side, tristate pads split into input, output and enable
  input  logic                           frame_ext,
  input  logic                           irdy_ext,
  input  logic                           trdy_ext,
  input  logic                           stop_ext,
  input  logic [`PCI_AD_WIDTH-1:0]       ad_ext,
  // Master and target command codes
  input  pci_ctrl_pkg::pci_frame_code_e  frame_code,
  input  logic                           frame_force,
  input  pci_ctrl_pkg::pci_irdy_code_e   irdy_code,
  input  pci_ctrl_pkg::pci_target_code_e devsel_code,
  input  pci_ctrl_pkg::pci_target_code_e trdy_code,
  input  pci_ctrl_pkg::pci_target_code_e stop_code,
  // Enable and data control
  input  logic                           master_oe_next,
  input  logic                           target_oe_next,
  input  logic                           ad_oe_next,
  input  logic                           master_expects_trdy,
  input  logic                           target_expects_irdy,
  input  logic                           new_data_unconditional,
  input  logic [`PCI_AD_WIDTH-1:0]       ad_out_next,
  // Registered pad outputs
  output logic                           frame_out,
  output logic                           irdy_out,
  output logic                           devsel_out,
  output logic                           trdy_out,
  output logic                           stop_out,
  output logic [`PCI_AD_WIDTH-1:0]       ad_out,
  output logic                           master_oe,
  output logic                           target_oe,
  output logic                           ad_oe,
  output logic [`PCI_AD_WIDTH-1:0]       ad_in_prev
);

  pci_sample_if sample_if ();
  pci_next_if   next_if ();
  pci_drive_if  drive_if ();

  // ==============================
  // Input side
  // ==============================

  pci_bus_sampler i_sampler (
    .pci_clk     (pci_clk),
    .async_reset (async_reset),
    .frame_ext   (frame_ext),
    .irdy_ext    (irdy_ext),
    .trdy_ext    (trdy_ext),
    .stop_ext    (stop_ext),
    .ad_ext      (ad_ext),
    .drive       (drive_if.dst),
    .sample      (sample_if.src),
    .ad_in_prev  (ad_in_prev)
  );

  // ==============================
  // Next-state decode
  // ==============================

  pci_master_next_ctrl i_master_next (
    .frame_code  (frame_code),
    .frame_force (frame_force),
    .irdy_code   (irdy_code),
    .sample      (sample_if.dst),
    .nxt         (next_if.master)
  );

  pci_target_next_ctrl i_target_next (
    .devsel_code (devsel_code),
    .trdy_code   (trdy_code),
    .stop_code   (stop_code),
    .sample      (sample_if.dst),
    .nxt         (next_if.target)
  );

  // ==============================
  // Output side
  // ==============================

  pci_pad_drivers i_pads (
    .pci_clk                (pci_clk),
    .async_reset            (async_reset),
    .master_oe_next         (master_oe_next),
    .target_oe_next         (target_oe_next),
    .ad_oe_next             (ad_oe_next),
    .master_expects_trdy    (master_expects_trdy),
    .target_expects_irdy    (target_expects_irdy),
    .new_data_unconditional (new_data_unconditional),
    .ad_out_next            (ad_out_next),
    .sample                 (sample_if.dst),
    .nxt                    (next_if.dst),
    .drive                  (drive_if.src),
    .frame_out              (frame_out),
    .irdy_out               (irdy_out),
    .devsel_out             (devsel_out),
    .trdy_out               (trdy_out),
    .stop_out               (stop_out),
    .ad_out                 (ad_out),
    .master_oe              (master_oe),
    .target_oe              (target_oe),
    .ad_oe                  (ad_oe)
  );

endmodule

`default_nettype wire

// File: tests/tb_pci_signal_ctrl.sv
/*
 * Directed testbench for the PCI signal-timing core with reset, FRAME/IRDY
 * and target decode, data latch enable and post-flop bypass tests and a watchdog
 */
`include "pci_ctrl_defs.svh"
`default_nettype none

module tb_pci_signal_ctrl;

  import pci_ctrl_pkg::*;

  localparam int clk_period = 100;
  localparam int drive_delay = 10;
  // The directed tests run for about 170 cycles, so this leaves a wide margin
  localparam int watchdog_cycles = 2000;

  logic                     pci_clk;
  logic                     async_reset;
  logic                     frame_ext;
  logic                     irdy_ext;
  logic                     trdy_ext;
  logic                     stop_ext;
  logic [`PCI_AD_WIDTH-1:0] ad_ext;
  pci_frame_code_e          frame_code;
  logic                     frame_force;
  pci_irdy_code_e           irdy_code;
  pci_target_code_e         devsel_code;
  pci_target_code_e         trdy_code;
  pci_target_code_e         stop_code;
  logic                     master_oe_next;
  logic                     target_oe_next;
  logic                     ad_oe_next;
  logic                     master_expects_trdy;
  logic                     target_expects_irdy;
  logic                     new_data_unconditional;
  logic [`PCI_AD_WIDTH-1:0] ad_out_next;
  logic                     frame_out;
  logic                     irdy_out;
  logic                     devsel_out;
  logic                     trdy_out;
  logic                     stop_out;
  logic [`PCI_AD_WIDTH-1:0] ad_out;
  logic                     master_oe;
  logic                     target_oe;
  logic                     ad_oe;
  logic [`PCI_AD_WIDTH-1:0] ad_in_prev;

  // Word that ad_out should hold as tracked from the latch enable rule
  logic [`PCI_AD_WIDTH-1:0] ad_expect;

  pci_signal_ctrl_top i_dut (
    .pci_clk                (pci_clk),
    .async_reset            (async_reset),
    .frame_ext              (frame_ext),
    .irdy_ext               (irdy_ext),
    .trdy_ext               (trdy_ext),
    .stop_ext               (stop_ext),
    .ad_ext                 (ad_ext),
    .frame_code             (frame_code),
    .frame_force            (frame_force),
    .irdy_code              (irdy_code),
    .devsel_code            (devsel_code),
    .trdy_code              (trdy_code),
    .stop_code              (stop_code),
    .master_oe_next         (master_oe_next),
    .target_oe_next         (target_oe_next),
    .ad_oe_next             (ad_oe_next),
    .master_expects_trdy    (master_expects_trdy),
    .target_expects_irdy    (target_expects_irdy),
    .new_data_unconditional (new_data_unconditional),
    .ad_out_next            (ad_out_next),
    .frame_out              (frame_out),
    .irdy_out               (irdy_out),
    .devsel_out             (devsel_out),
    .trdy_out               (trdy_out),
    .stop_out               (stop_out),
    .ad_out                 (ad_out),
    .master_oe              (master_oe),
    .target_oe              (target_oe),
    .ad_oe                  (ad_oe),
    .ad_in_prev             (ad_in_prev)
  );

  // ==============================
  // Clock and watchdog
  // ==============================

  initial
  begin
    pci_clk = 1'b0;
    forever #(clk_period / 2) pci_clk = ~pci_clk;
  end

  initial
  begin
    repeat (watchdog_cycles) @(posedge pci_clk);
    $display("Watchdog expired after %0d cycles before the tests finished", watchdog_cycles);
    $display("TEST FAIL");
    $fatal(1, "Simulation timed out");
  end

  // ==============================
  // Reference model
  // ==============================

  // Idle has neither TRDY nor STOP and abort is STOP without TRDY
  function automatic logic frame_model(pci_frame_code_e code, logic trdy, logic stop);
    logic result;
    result = 1'b0;
    case (code)
      frame_off:         result = 1'b0;
      frame_hold:        result = !(stop && !trdy);
      frame_end_on_stop: result = !stop;
      frame_end_on_any:  result = !trdy && !stop;
    endcase
    return result;
  endfunction

  // Codes past irdy_on keep IRDY asserted
  function automatic logic irdy_model(pci_irdy_code_e code, logic trdy, logic stop);
    logic result;
    case (code)
      irdy_off:       result = 1'b0;
      irdy_on_abort:  result = stop && !trdy;
      irdy_hold_last: result = (!trdy && !stop) || (trdy && stop);
      irdy_hold_idle: result = !trdy && !stop;
      default:        result = 1'b1;
    endcase
    return result;
  endfunction

  // Code 001 acts as off and 101 to 111 act as on
  function automatic logic target_model(pci_target_code_e code, logic frame, logic irdy);
    logic result;
    case (code)
      tgt_off:       result = 1'b0;
      tgt_hold_last: result = !irdy || frame;
      tgt_hold_idle: result = !irdy;
      default:       result = code[2];
    endcase
    return result;
  endfunction

  // ==============================
  // Compare tasks
  // ==============================

  task automatic report_mismatch(input string name, input logic [`PCI_AD_WIDTH-1:0] expected,
                                 input logic [`PCI_AD_WIDTH-1:0] actual);
    $display("Error at time %0t: %s expected %0h, actual %0h", $time, name, expected, actual);
    $display("TEST FAIL");
    $fatal(1, "Compare failed on %s", name);
  endtask

  task automatic check_bit(input string name, input logic expected, input logic actual);
    if (actual !== expected)
    begin
      report_mismatch(name, `PCI_AD_WIDTH'(expected), `PCI_AD_WIDTH'(actual));
    end
  endtask

  task automatic check_ad(input string name, input logic [`PCI_AD_WIDTH-1:0] expected,
                          input logic [`PCI_AD_WIDTH-1:0] actual);
    if (actual !== expected)
    begin
      report_mismatch(name, expected, actual);
    end
  endtask

  task automatic check_frame_code_result(input pci_frame_code_e code, input logic trdy,
                                         input logic stop, input logic observed);
    check_bit("frame_out", frame_model(code, trdy, stop), observed);
  endtask

  task automatic check_irdy_code_result(input pci_irdy_code_e code, input logic trdy,
                                        input logic stop, input logic observed);
    check_bit("irdy_out", irdy_model(code, trdy, stop), observed);
  endtask

  task automatic check_target_code_result(input string name, input pci_target_code_e code,
                                          input logic frame, input logic irdy,
                                          input logic observed);
    check_bit(name, target_model(code, frame, irdy), observed);
  endtask

  task automatic check_outputs_cleared();
    check_bit("master_oe", 1'b0, master_oe);
    check_bit("target_oe", 1'b0, target_oe);
    check_bit("ad_oe", 1'b0, ad_oe);
    check_bit("frame_out", 1'b0, frame_out);
    check_bit("irdy_out", 1'b0, irdy_out);
    check_bit("devsel_out", 1'b0, devsel_out);
    check_bit("trdy_out", 1'b0, trdy_out);
    check_bit("stop_out", 1'b0, stop_out);
    check_ad("ad_out", '0, ad_out);
  endtask

  // ==============================
  // Stimulus helpers
  // ==============================

  // Outputs are stable here and new inputs go out right after the checks
  task automatic next_cycle();
    @(posedge pci_clk);
    #(drive_delay);
  endtask

  task automatic initialize_inputs();
    async_reset            = 1'b1;
    frame_ext              = 1'b0;
    irdy_ext               = 1'b0;
    trdy_ext               = 1'b0;
    stop_ext               = 1'b0;
    ad_ext                 = '0;
    frame_code             = frame_off;
    frame_force            = 1'b0;
    irdy_code              = irdy_off;
    devsel_code            = tgt_off;
    trdy_code              = tgt_off;
    stop_code              = tgt_off;
    master_oe_next         = 1'b0;
    target_oe_next         = 1'b0;
    ad_oe_next             = 1'b0;
    master_expects_trdy    = 1'b0;
    target_expects_irdy    = 1'b0;
    new_data_unconditional = 1'b0;
    ad_out_next            = '0;
    ad_expect              = '0;
  endtask

  // Sets every enable, force and code at once
  task automatic set_all_active(input logic value);
    master_oe_next = value;
    target_oe_next = value;
    ad_oe_next     = value;
    frame_force    = value;
    frame_code     = frame_off;
    irdy_code      = value ? irdy_on : irdy_off;
    devsel_code    = value ? tgt_on : tgt_off;
    trdy_code      = value ? tgt_on : tgt_off;
    stop_code      = value ? tgt_on : tgt_off;
  endtask

  // ==============================
  // Directed tests
  // ==============================

  // Active next values during reset must never reach the registers
  task automatic run_reset_test();
    set_all_active(1'b1);
    repeat (8)
    begin
      next_cycle();
      check_outputs_cleared();
    end
    set_all_active(1'b0);
    async_reset = 1'b0;
    next_cycle();
    check_outputs_cleared();
  endtask

  // Every code with every TRDY/STOP pin pair both with and without force
  task automatic run_master_decode_test();
    int code_idx;
    int force_idx;
    int pair_idx;
    for (code_idx = 0; code_idx < 8; code_idx++)
    begin
      for (force_idx = 0; force_idx < 2; force_idx++)
      begin
        for (pair_idx = 0; pair_idx < 4; pair_idx++)
        begin
          frame_code  = pci_frame_code_e'(code_idx[1:0]);
          irdy_code   = pci_irdy_code_e'(code_idx[2:0]);
          frame_force = force_idx[0];
          trdy_ext    = pair_idx[1];
          stop_ext    = pair_idx[0];
          next_cycle();
          if (frame_force)
          begin
            check_bit("frame_out", 1'b1, frame_out);
          end
          else
          begin
            check_frame_code_result(frame_code, trdy_ext, stop_ext, frame_out);
          end
          check_irdy_code_result(irdy_code, trdy_ext, stop_ext, irdy_out);
        end
      end
    end
    frame_force = 1'b0;
    trdy_ext    = 1'b0;
    stop_ext    = 1'b0;
  endtask

  // The three target codes are rotated so each signal sees a different code
  task automatic run_target_decode_test();
    int code_idx;
    int pair_idx;
    logic [2:0] code_bits;
    for (code_idx = 0; code_idx < 8; code_idx++)
    begin
      for (pair_idx = 0; pair_idx < 4; pair_idx++)
      begin
        code_bits   = code_idx[2:0];
        devsel_code = pci_target_code_e'(code_bits);
        trdy_code   = pci_target_code_e'(code_bits + 3'd3);
        stop_code   = pci_target_code_e'(code_bits + 3'd5);
        frame_ext   = pair_idx[1];
        irdy_ext    = pair_idx[0];
        next_cycle();
        check_target_code_result("devsel_out", devsel_code, frame_ext, irdy_ext, devsel_out);
        check_target_code_result("trdy_out", trdy_code, frame_ext, irdy_ext, trdy_out);
        check_target_code_result("stop_out", stop_code, frame_ext, irdy_ext, stop_out);
      end
    end
    frame_ext = 1'b0;
    irdy_ext  = 1'b0;
  endtask

  // All 32 combinations of the three enable terms and their qualifiers
  task automatic run_latch_enable_test();
    int term_idx;
    logic latch;
    logic [`PCI_AD_WIDTH-1:0] new_word;
    new_data_unconditional = 1'b1;
    ad_out_next = $urandom;
    ad_expect = ad_out_next;
    next_cycle();
    check_ad("ad_out", ad_expect, ad_out);
    for (term_idx = 0; term_idx < 32; term_idx++)
    begin
      master_expects_trdy    = term_idx[4];
      trdy_ext               = term_idx[3];
      target_expects_irdy    = term_idx[2];
      irdy_ext               = term_idx[1];
      new_data_unconditional = term_idx[0];
      new_word = $urandom;
      ad_out_next = new_word;
      latch = (term_idx[4] && term_idx[3]) || (term_idx[2] && term_idx[1]) || term_idx[0];
      next_cycle();
      if (latch)
      begin
        ad_expect = new_word;
      end
      check_ad("ad_out", ad_expect, ad_out);
    end
    master_expects_trdy    = 1'b0;
    target_expects_irdy    = 1'b0;
    new_data_unconditional = 1'b0;
    trdy_ext               = 1'b0;
    irdy_ext               = 1'b0;
  endtask

  // AD and TRDY/STOP samples come from the chip's own registers while driven
  task automatic run_bypass_test();
    int cycle_idx;
    int code_idx;
    logic [`PCI_AD_WIDTH-1:0] pin_word;
    ad_oe_next = 1'b1;
    new_data_unconditional = 1'b1;
    ad_out_next = $urandom;
    ad_expect = ad_out_next;
    next_cycle();
    new_data_unconditional = 1'b0;
    ad_ext = ~ad_expect;
    next_cycle();
    check_ad("ad_out", ad_expect, ad_out);
    check_ad("ad_in_prev", ad_expect, ad_in_prev);
    // The edge that turns ad_oe off still samples the register
    ad_oe_next = 1'b0;
    next_cycle();
    check_ad("ad_in_prev", ad_expect, ad_in_prev);
    for (cycle_idx = 0; cycle_idx < 8; cycle_idx++)
    begin
      pin_word = $urandom;
      ad_ext = pin_word;
      next_cycle();
      check_ad("ad_in_prev", pin_word, ad_in_prev);
    end

    // Chip drives a data phase while the pins show an abort
    target_oe_next = 1'b1;
    trdy_code = tgt_on;
    stop_code = tgt_off;
    trdy_ext = 1'b0;
    stop_ext = 1'b1;
    next_cycle();
    check_bit("trdy_out", 1'b1, trdy_out);
    check_bit("stop_out", 1'b0, stop_out);
    for (code_idx = 0; code_idx < 4; code_idx++)
    begin
      frame_code = pci_frame_code_e'(code_idx[1:0]);
      next_cycle();
      check_frame_code_result(frame_code, 1'b1, 1'b0, frame_out);
    end

    // Chip drives an abort while the pins show a data phase
    trdy_code = tgt_off;
    stop_code = tgt_on;
    trdy_ext = 1'b1;
    stop_ext = 1'b0;
    next_cycle();
    check_bit("trdy_out", 1'b0, trdy_out);
    check_bit("stop_out", 1'b1, stop_out);
    for (code_idx = 0; code_idx < 4; code_idx++)
    begin
      frame_code = pci_frame_code_e'(code_idx[1:0]);
      next_cycle();
      check_frame_code_result(frame_code, 1'b0, 1'b1, frame_out);
    end
    set_all_active(1'b0);
    trdy_ext = 1'b0;
    next_cycle();
  endtask

  // Reset raised in the middle of a cycle clears the enables before any edge
  task automatic run_async_reset_test();
    set_all_active(1'b1);
    next_cycle();
    check_bit("master_oe", 1'b1, master_oe);
    check_bit("target_oe", 1'b1, target_oe);
    check_bit("ad_oe", 1'b1, ad_oe);
    check_bit("frame_out", 1'b1, frame_out);
    check_bit("irdy_out", 1'b1, irdy_out);
    #20;
    async_reset = 1'b1;
    #1;
    check_outputs_cleared();
    next_cycle();
    check_outputs_cleared();
    set_all_active(1'b0);
    async_reset = 1'b0;
    next_cycle();
    check_outputs_cleared();
  endtask

  // ==============================
  // Test sequence
  // ==============================

  initial
  begin
    void'($urandom(32'h38ac));
    initialize_inputs();
    run_reset_test();
    run_master_decode_test();
    run_target_decode_test();
    run_latch_enable_test();
    run_bypass_test();
    run_async_reset_test();
    $display("TEST PASS");
    $finish;
  end

endmodule

`default_nettype wire

// File: flist.f
+incdir+design
design/pci_ctrl_pkg.sv
design/pci_ctrl_ifs.sv
design/pci_bus_sampler.sv
design/pci_master_next_ctrl.sv
design/pci_target_next_ctrl.sv
design/pci_pad_drivers.sv
design/pci_signal_ctrl_top.sv
tests/tb_pci_signal_ctrl.sv

// File: run_sim.sh
#!/bin/sh
# Builds the PCI signal-timing core with its testbench and runs it.
# A failing check ends the simulation with $fatal, which gives a nonzero status.
set -e

cd "$(dirname "$0")"

verilator --binary --assert \
  --top-module tb_pci_signal_ctrl \
  -f flist.f \
  -o tb_pci_signal_ctrl

./obj_dir/tb_pci_signal_ctrl
